/* build.f */
+incdir+include
hw/cpc_loader_pkg.sv
hw/rom_loader.sv
hw/tape_buffer.sv
hw/mem_write_sched.sv
hw/cpc_loader_top.sv
testbench/cpc_loader_props.sv
testbench/cpc_loader_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= cpc_loader_tb
RTL_TOP    ?= cpc_loader_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
INC_DIR    ?= include
PASS_MSG   ?= NO ERRORS
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only
RTL_SRCS   ?= hw/cpc_loader_pkg.sv hw/rom_loader.sv hw/tape_buffer.sv \
              hw/mem_write_sched.sv hw/cpc_loader_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+$(INC_DIR) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/cpc_loader_tb.sv */
////////////////////////////////////////
// Download loader testbench
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "cpc_loader_cfg.svh"

module cpc_loader_tb import cpc_loader_pkg::*; ();

	localparam int SLOT          = `CPC_SLOT_DIV;
	localparam int RST_CYC       = 8;
	localparam int ROM_BYTE_CYC  = 2 * SLOT + 8;
	localparam int TAPE_BYTE_CYC = SLOT + 4;
	localparam int WAIT_LIMIT    = 3 * SLOT;
	// Reset check, main ROM, expansion with ZZ, high bank, tape
	localparam int TEST_CYC = RST_CYC
		+ RST_CYC + 9 * ROM_BYTE_CYC + 2 * SLOT
		+ RST_CYC + 5 * ROM_BYTE_CYC + 8
		+ RST_CYC + 2 * ROM_BYTE_CYC + 4
		+ RST_CYC + 6 * TAPE_BYTE_CYC + 8 * 3 + 8;
	localparam int TIMEOUT_CYC = 2 * TEST_CYC;

	logic       clk_sys;
	logic       reset;
	logic       ioctl_download;
	logic       ioctl_wr;
	host_addr_t ioctl_addr;
	byte_t      ioctl_dout;
	byte_t      ioctl_index;
	logic [15:0] ioctl_file_ext;
	logic       ioctl_wait;
	logic       tape_data_ack;
	logic       tape_rewind;
	mem_addr_t  tape_last_addr;
	mem_addr_t  tape_play_addr;
	logic       tape_ready;
	logic       mem_we;
	mem_addr_t  mem_addr;
	byte_t      mem_din;
	bank_t      mem_bank;
	rom_map_t   rom_map;

	integer seed = 74;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int cycle_cnt = 0;
	// Captured writes as {bank, address, data}
	logic [32:0] wr_q[$];

	cpc_loader_top dut_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wait     (ioctl_wait),
		.tape_data_ack  (tape_data_ack),
		.tape_rewind    (tape_rewind),
		.tape_last_addr (tape_last_addr),
		.tape_play_addr (tape_play_addr),
		.tape_ready     (tape_ready),
		.mem_we         (mem_we),
		.mem_addr       (mem_addr),
		.mem_din        (mem_din),
		.mem_bank       (mem_bank),
		.rom_map        (rom_map)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(negedge clk_sys) begin
		if (mem_we)
			wr_q.push_back({mem_bank, mem_addr, mem_din});
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("timeout after %0d cycles, a test did not finish", cycle_cnt);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	////////////////////////////////////////
	// Checks and host helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		idle(1);
		wr_q.delete();
	endtask

	task automatic start_download(input byte_t index, input logic [15:0] ext);
		@(posedge clk_sys);
		ioctl_index    <= index;
		ioctl_file_ext <= ext;
		ioctl_download <= 1'b1;
		@(posedge clk_sys);
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		idle(1);
	endtask

	task automatic send_byte(input host_addr_t addr, input byte_t data);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic wait_rom_done(input logic wait_expected);
		int n;
		n = 0;
		@(negedge clk_sys);
		check_value("ioctl_wait", ioctl_wait, wait_expected);
		while (ioctl_wait && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (ioctl_wait) begin
			$display("ioctl_wait did not fall within %0d cycles at %0t", WAIT_LIMIT, $time);
			errors++;
		end
	endtask

	task automatic expect_write(input mem_addr_t addr, input byte_t data, input bank_t bank);
		logic [32:0] w;
		if (wr_q.size() == 0) begin
			$display("missing memory write at %0t, expected bank %0d address 0x%06h",
				$time, bank, addr);
			errors++;
		end else begin
			w = wr_q.pop_front();
			check_value("mem_bank", w[32:31], bank);
			check_value("mem_addr", w[30:8], addr);
			check_value("mem_din", w[7:0], data);
		end
	endtask

	task automatic expect_no_more_writes();
		logic [32:0] w;
		while (wr_q.size() != 0) begin
			w = wr_q.pop_front();
			$display("unexpected memory write to bank %0d address 0x%06h before %0t",
				w[32:31], w[30:8], $time);
			errors++;
		end
	endtask

	// One host byte, then the write or the bank 0 and bank 1 pair it must cause
	task automatic send_rom_byte(input host_addr_t addr, input rom_page_t page,
			input bank_t bank, input logic dual);
		byte_t d;
		mem_addr_t exp_addr;
		d = byte_t'($random(seed));
		exp_addr = {page, addr[13:0]};
		send_byte(addr, d);
		wait_rom_done(1'b1);
		expect_write(exp_addr, d, bank);
		if (dual)
			expect_write(exp_addr, d, 2'd1);
	endtask

	function automatic rom_page_t main_rom_page(input int chunk);
		case (chunk % 4)
			0:       return `CPC_PAGE_OS;
			1:       return `CPC_PAGE_BASIC;
			2:       return `CPC_PAGE_AMSDOS;
			default: return `CPC_PAGE_MF2;
		endcase
	endfunction

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before)
			$display("test %s passed", name);
		else
			$display("test %s failed with %0d errors", name, errors - err_before);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset_state();
		int err0;
		err0 = errors;
		idle(1);
		check_value("mem_we", mem_we, 0);
		check_value("ioctl_wait", ioctl_wait, 0);
		check_value("tape_ready", tape_ready, 0);
		check_value("rom_map", rom_map, 0);
		check_value("tape_last_addr", tape_last_addr, 0);
		check_value("tape_play_addr", tape_play_addr, 0);
		finish_test("reset state", err0);
	endtask

	task automatic test_main_rom();
		int err0;
		rom_page_t pg;
		rom_map_t exp_map;
		err0 = errors;
		exp_map = '0;
		apply_reset();
		start_download(8'd0, "RM");
		for (int c = 0; c < 8; c++) begin
			pg = main_rom_page(c);
			send_rom_byte(host_addr_t'(c * 16384 + 5), pg, (c < 4) ? 2'd0 : 2'd1, 1'b0);
			// Upper-ROM pages mark the map
			if (pg[8])
				exp_map[pg[7:0]] = 1'b1;
		end
		// Chunk 8 is past the 664 set
		send_byte(host_addr_t'(8 * 16384 + 5), 8'h5A);
		wait_rom_done(1'b0);
		idle(2 * SLOT);
		end_download();
		expect_no_more_writes();
		check_value("rom_map", rom_map, exp_map);
		finish_test("main ROM", err0);
	endtask

	task automatic test_expansion();
		int err0;
		err0 = errors;
		apply_reset();
		// Index 3 is a manual load, both banks
		start_download(8'd3, "0A");
		send_rom_byte(25'h0000, 9'h10A, 2'd0, 1'b1);
		send_rom_byte(25'h1234, 9'h10A, 2'd0, 1'b1);
		send_rom_byte(25'h3FFF, 9'h10A, 2'd0, 1'b1);
		end_download();
		check_value("rom_map", rom_map, rom_map_t'(1) << 10);
		start_download(8'd3, "ZZ");
		send_rom_byte(25'h0010, 9'h000, 2'd0, 1'b1);
		send_rom_byte(25'h2000, 9'h000, 2'd0, 1'b1);
		end_download();
		check_value("rom_map", rom_map, rom_map_t'(1) << 10);
		expect_no_more_writes();
		finish_test("expansion ROM", err0);
	endtask

	task automatic test_high_bank();
		int err0;
		err0 = errors;
		apply_reset();
		start_download(8'hC0, "1F");
		send_rom_byte(25'h0042, 9'h11F, 2'd1, 1'b0);
		send_rom_byte(25'h3FFE, 9'h11F, 2'd1, 1'b0);
		end_download();
		check_value("rom_map", rom_map, rom_map_t'(1) << 31);
		expect_no_more_writes();
		finish_test("high bank ROM", err0);
	endtask

	task automatic toggle_ack();
		@(posedge clk_sys);
		tape_data_ack <= ~tape_data_ack;
		idle(2);
	endtask

	task automatic test_tape();
		int err0;
		byte_t d;
		err0 = errors;
		apply_reset();
		start_download(`CPC_TAPE_INDEX, "CD");
		for (int a = 0; a < 6; a++) begin
			d = byte_t'($random(seed));
			send_byte(host_addr_t'(a), d);
			// Acks during a download leave the play pointer at 0
			tape_data_ack <= ~tape_data_ack;
			idle(SLOT + 2);
			check_value("tape_last_addr", tape_last_addr, a);
			check_value("tape_play_addr", tape_play_addr, 0);
			expect_write(mem_addr_t'(a), d, `CPC_TAPE_BANK);
		end
		end_download();
		check_value("tape_ready", tape_ready, 1);
		repeat (3) toggle_ack();
		check_value("tape_play_addr", tape_play_addr, 3);
		check_value("tape_ready", tape_ready, 1);
		// Play pointer stops at the last byte
		repeat (4) toggle_ack();
		check_value("tape_play_addr", tape_play_addr, 5);
		check_value("tape_ready", tape_ready, 1);
		@(posedge clk_sys);
		tape_rewind <= 1'b1;
		@(posedge clk_sys);
		tape_rewind <= 1'b0;
		idle(1);
		check_value("tape_last_addr", tape_last_addr, 0);
		check_value("tape_play_addr", tape_play_addr, 0);
		check_value("tape_ready", tape_ready, 0);
		expect_no_more_writes();
		finish_test("tape buffer", err0);
	endtask

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_index    = '0;
		ioctl_file_ext = '0;
		tape_data_ack  = 1'b0;
		tape_rewind    = 1'b0;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		test_reset_state();
		test_main_rom();
		test_expansion();
		test_high_bank();
		test_tape();
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/cpc_loader_props.sv */
////////////////////////////////////////
// Memory port assertions
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module cpc_loader_props (
	input wire clk_sys,
	input wire reset,
	input wire mem_we,
	input wire rom_grant,
	input wire tape_grant,
	input wire rom_req,
	input wire ioctl_wait
);

	// Write strobe is a single-cycle pulse
	we_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		mem_we |=> !mem_we)
		else $error("mem_we stayed high for more than one cycle");

	grant_with_we: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_grant || tape_grant) |-> mem_we)
		else $error("grant without mem_we");

	// One winner per slot
	grants_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_grant && tape_grant))
		else $error("ROM and tape grants high together");

	wait_needs_req: assert property (@(posedge clk_sys) disable iff (reset)
		!rom_req |-> !ioctl_wait)
		else $error("ioctl_wait high without a ROM request");

endmodule

// Scheduler grants and the host wait on the loader top
bind cpc_loader_top cpc_loader_props props_i (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.mem_we     (mem_we),
	.rom_grant  (rom_grant),
	.tape_grant (tape_grant),
	.rom_req    (rom_req),
	.ioctl_wait (ioctl_wait)
);

`default_nettype wire

/* hw/cpc_loader_top.sv */
////////////////////////////////////////
// Download loader top
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module cpc_loader_top import cpc_loader_pkg::*; (
	input  wire        clk_sys,
	input  wire        reset,
	// Host download port
	input  wire        ioctl_download,
	input  wire        ioctl_wr,
	input  host_addr_t ioctl_addr,
	input  byte_t      ioctl_dout,
	input  byte_t      ioctl_index,
	input  wire [15:0] ioctl_file_ext,
	output wire        ioctl_wait,
	// Tape player side
	input  wire        tape_data_ack,
	input  wire        tape_rewind,
	output mem_addr_t  tape_last_addr,
	output mem_addr_t  tape_play_addr,
	output wire        tape_ready,
	// Shared memory write port
	output wire        mem_we,
	output mem_addr_t  mem_addr,
	output byte_t      mem_din,
	output bank_t      mem_bank,
	output rom_map_t   rom_map
);

	wire       rom_req;
	wire       rom_grant;
	mem_addr_t rom_addr;
	byte_t     rom_data;
	bank_t     rom_bank;

	wire       tape_req;
	wire       tape_grant;
	mem_addr_t tape_addr;
	byte_t     tape_data;

	rom_loader rom_loader_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.rom_grant      (rom_grant),
		.rom_req        (rom_req),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.rom_bank       (rom_bank),
		.ioctl_wait     (ioctl_wait),
		.rom_map        (rom_map)
	);

	tape_buffer tape_buffer_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_index    (ioctl_index),
		.tape_grant     (tape_grant),
		.tape_rewind    (tape_rewind),
		.tape_data_ack  (tape_data_ack),
		.tape_req       (tape_req),
		.tape_addr      (tape_addr),
		.tape_data      (tape_data),
		.tape_last_addr (tape_last_addr),
		.tape_play_addr (tape_play_addr),
		.tape_ready     (tape_ready)
	);

	mem_write_sched mem_write_sched_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.rom_req    (rom_req),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.rom_bank   (rom_bank),
		.tape_req   (tape_req),
		.tape_addr  (tape_addr),
		.tape_data  (tape_data),
		.rom_grant  (rom_grant),
		.tape_grant (tape_grant),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_din    (mem_din),
		.mem_bank   (mem_bank)
	);

endmodule

`default_nettype wire

/* hw/mem_write_sched.sv */
////////////////////////////////////////
// Memory write slot arbiter
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "cpc_loader_cfg.svh"

module mem_write_sched import cpc_loader_pkg::*; (
	input  wire       clk_sys,
	input  wire       reset,
	input  wire       rom_req,
	input  mem_addr_t rom_addr,
	input  byte_t     rom_data,
	input  bank_t     rom_bank,
	input  wire       tape_req,
	input  mem_addr_t tape_addr,
	input  byte_t     tape_data,
	output logic      rom_grant,
	output logic      tape_grant,
	output logic      mem_we,
	output mem_addr_t mem_addr,
	output byte_t     mem_din,
	output bank_t     mem_bank
);

	localparam int SLOT_DIV = `CPC_SLOT_DIV;
	localparam int SLOT_W   = $clog2(SLOT_DIV);

	logic [SLOT_W-1:0] slot_cnt;
	logic              slot_ce;
	logic              pick_rom;
	logic              pick_tape;

	////////////////////////////////////////
	// Slot clock enable
	////////////////////////////////////////

	assign slot_ce = (slot_cnt == SLOT_W'(SLOT_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			slot_cnt <= '0;
		end else if (slot_ce) begin
			slot_cnt <= '0;
		end else begin
			slot_cnt <= slot_cnt + 1'b1;
		end
	end

	// ROM loader always wins the slot
	assign pick_rom  = slot_ce & rom_req;
	assign pick_tape = slot_ce & tape_req & ~rom_req;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_we     <= 1'b0;
			rom_grant  <= 1'b0;
			tape_grant <= 1'b0;
		end else begin
			mem_we     <= pick_rom | pick_tape;
			rom_grant  <= pick_rom;
			tape_grant <= pick_tape;
		end
	end

	// Write payload for the winner
	always_ff @(posedge clk_sys) begin
		if (pick_rom) begin
			mem_addr <= rom_addr;
			mem_din  <= rom_data;
			mem_bank <= rom_bank;
		end else if (pick_tape) begin
			mem_addr <= tape_addr;
			mem_din  <= tape_data;
			mem_bank <= `CPC_TAPE_BANK;
		end
	end

endmodule

`default_nettype wire

/* hw/tape_buffer.sv */
////////////////////////////////////////
// Tape image buffer
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "cpc_loader_cfg.svh"

module tape_buffer import cpc_loader_pkg::*; (
	input  wire       clk_sys,
	input  wire       reset,
	input  wire       ioctl_download,
	input  wire       ioctl_wr,
	input  host_addr_t ioctl_addr,
	input  byte_t     ioctl_dout,
	input  byte_t     ioctl_index,
	input  wire       tape_grant,
	input  wire       tape_rewind,
	input  wire       tape_data_ack,
	output logic      tape_req,
	output mem_addr_t tape_addr,
	output byte_t     tape_data,
	output mem_addr_t tape_last_addr,
	output mem_addr_t tape_play_addr,
	output logic      tape_ready
);

	logic tape_dl;
	logic tape_byte;
	logic ack_prev;
	logic ack_toggle;

	assign tape_dl    = ioctl_download && (ioctl_index == `CPC_TAPE_INDEX);
	assign tape_byte  = tape_dl & ioctl_wr;
	assign ack_toggle = ack_prev ^ tape_data_ack;

	// Pending write, cleared by the scheduler
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tape_req <= 1'b0;
		end else begin
			if (tape_grant)
				tape_req <= 1'b0;
			if (tape_byte)
				tape_req <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (tape_byte) begin
			tape_addr <= ioctl_addr[`CPC_MEM_ADDR_W-1:0];
			tape_data <= ioctl_dout;
		end
	end

	////////////////////////////////////////
	// Record and play pointers
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || tape_rewind) begin
			ack_prev       <= tape_data_ack;
			tape_last_addr <= '0;
			tape_play_addr <= '0;
		end else begin
			ack_prev <= tape_data_ack;
			if (tape_byte)
				tape_last_addr <= ioctl_addr[`CPC_MEM_ADDR_W-1:0];
			// Player restarts from the top on a new image
			if (tape_dl)
				tape_play_addr <= '0;
			else if (ack_toggle && (tape_play_addr < tape_last_addr))
				tape_play_addr <= tape_play_addr + 1'b1;
		end
	end

	assign tape_ready = (|tape_last_addr) && (tape_play_addr <= tape_last_addr);

endmodule

`default_nettype wire

/* hw/rom_loader.sv */
////////////////////////////////////////
// ROM download decoder
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "cpc_loader_cfg.svh"

module rom_loader import cpc_loader_pkg::*; (
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        ioctl_download,
	input  wire        ioctl_wr,
	input  host_addr_t ioctl_addr,
	input  byte_t      ioctl_dout,
	input  byte_t      ioctl_index,
	input  wire [15:0] ioctl_file_ext,
	input  wire        rom_grant,
	output logic       rom_req,
	output mem_addr_t  rom_addr,
	output byte_t      rom_data,
	output bank_t      rom_bank,
	output logic       ioctl_wait,
	output rom_map_t   rom_map
);

	logic       pending;
	logic       dl_prev;
	rom_page_t  page;
	logic       combo;

	logic       rom_dl;
	logic       expansion;
	logic       dl_start;
	logic       dual_bank;
	logic       reissue;
	logic       byte_ok;

	logic [4:0] ext_hi;
	logic [4:0] ext_lo;
	rom_page_t  ext_page;
	logic       ext_combo;

	logic [10:0] chunk;
	rom_page_t   main_page;
	bank_t       main_bank;
	logic        main_valid;
	rom_page_t   exp_page;

	// Returns {valid, value} for one ASCII hex digit, upper case only
	function automatic logic [4:0] hex_nibble(input byte_t c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign rom_dl    = ioctl_download && (ioctl_index[4:0] < `CPC_ROM_INDEX_LIMIT);
	assign expansion = |ioctl_index;
	assign dl_start  = ~dl_prev & ioctl_download & rom_dl & expansion;

	// Manually loaded expansions go to both banks
	assign dual_bank = (ioctl_index[7:6] == 2'b01) || (|ioctl_index[5:0]);
	assign reissue   = dual_bank && (rom_bank == 2'd0);

	////////////////////////////////////////
	// Extension to base page
	////////////////////////////////////////

	always_comb begin
		ext_hi    = hex_nibble(ioctl_file_ext[15:8]);
		ext_lo    = hex_nibble(ioctl_file_ext[7:0]);
		ext_page  = `CPC_PAGE_BAD_EXT;
		ext_combo = 1'b0;
		if (ext_hi[4])
			ext_page[7:4] = ext_hi[3:0];
		if (ext_lo[4])
			ext_page[3:0] = ext_lo[3:0];
		if (ioctl_file_ext == "ZZ")
			ext_page = 9'h000;
		// Combo image, lower ROM followed by page 0x1FF
		if (ioctl_file_ext == "Z0") begin
			ext_page  = 9'h000;
			ext_combo = 1'b1;
		end
	end

	////////////////////////////////////////
	// Main ROM chunk map
	////////////////////////////////////////

	assign chunk = ioctl_addr[24:14];

	always_comb begin
		main_page  = `CPC_PAGE_OS;
		main_bank  = 2'd0;
		main_valid = 1'b1;
		case (chunk)
			11'd0, 11'd4: main_page = `CPC_PAGE_OS;
			11'd1, 11'd5: main_page = `CPC_PAGE_BASIC;
			11'd2, 11'd6: main_page = `CPC_PAGE_AMSDOS;
			11'd3, 11'd7: main_page = `CPC_PAGE_MF2;
			default:      main_valid = 1'b0;
		endcase
		// Upper half of the file is the 664 set
		if (chunk[2])
			main_bank = 2'd1;
	end

	// Expansion page advances with the chunk number
	assign exp_page = {page[8], page[7:0] + ioctl_addr[21:14]};

	assign byte_ok = rom_dl & ioctl_wr & (expansion | main_valid);

	////////////////////////////////////////
	// Request control and ROM map
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending <= 1'b0;
			dl_prev <= 1'b0;
			page    <= 9'h000;
			combo   <= 1'b0;
			rom_map <= '0;
		end else begin
			dl_prev <= ioctl_download;
			if (dl_start) begin
				page  <= ext_page;
				combo <= ext_combo;
			end
			if (rom_grant && !reissue) begin
				pending <= 1'b0;
				if (rom_addr[22])
					rom_map[rom_addr[21:14]] <= 1'b1;
				// Last byte of the combo's first chunk
				if (combo && (&rom_addr[13:0])) begin
					combo <= 1'b0;
					page  <= `CPC_PAGE_COMBO_NEXT;
				end
			end
			if (byte_ok)
				pending <= 1'b1;
		end
	end

	// Write payload, bank flips for the second copy
	always_ff @(posedge clk_sys) begin
		if (byte_ok) begin
			rom_data <= ioctl_dout;
			if (expansion) begin
				rom_addr <= {exp_page, ioctl_addr[13:0]};
				rom_bank <= {1'b0, &ioctl_index[7:6]};
			end else begin
				rom_addr <= {main_page, ioctl_addr[13:0]};
				rom_bank <= main_bank;
			end
		end else if (rom_grant && reissue) begin
			rom_bank <= 2'd1;
		end
	end

	assign rom_req    = pending;
	assign ioctl_wait = pending;

endmodule

`default_nettype wire

/* hw/cpc_loader_pkg.sv */
////////////////////////////////////////
// Loader shared types
////////////////////////////////////////

`default_nettype none

`include "cpc_loader_cfg.svh"

package cpc_loader_pkg;

	// Raw byte from the host or to memory
	typedef logic [7:0] byte_t;

	// Byte address on the shared memory port
	typedef logic [`CPC_MEM_ADDR_W-1:0] mem_addr_t;

	// Byte offset inside the downloaded file
	typedef logic [`CPC_HOST_ADDR_W-1:0] host_addr_t;

	// Memory bank select
	typedef logic [1:0] bank_t;

	// 16 KB page, top bit marks the upper-ROM area
	typedef logic [8:0] rom_page_t;

	// One presence flag per upper-ROM slot
	typedef logic [255:0] rom_map_t;

endpackage

`default_nettype wire

/* include/cpc_loader_cfg.svh */
////////////////////////////////////////
// Download loader constants
////////////////////////////////////////

`ifndef CPC_LOADER_CFG_SVH
`define CPC_LOADER_CFG_SVH

// Bus widths
`define CPC_MEM_ADDR_W       23
`define CPC_HOST_ADDR_W      25

// Memory slot timing, in clk_sys cycles
`define CPC_SLOT_DIV         8

// Host file indices
`define CPC_TAPE_INDEX       8'd4
`define CPC_ROM_INDEX_LIMIT  5'd4

// Tape image lives in its own bank
`define CPC_TAPE_BANK        2'd2

// 16 KB page numbers, bit 8 selects the upper-ROM half
`define CPC_PAGE_OS          9'h000
`define CPC_PAGE_BASIC       9'h100
`define CPC_PAGE_AMSDOS      9'h107
`define CPC_PAGE_MF2         9'h0FF
`define CPC_PAGE_BAD_EXT     9'h1EE
`define CPC_PAGE_COMBO_NEXT  9'h1FF

`endif
